// ==== design/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

	parameter int xlen = 64;

	// major opcodes of the supported base integer instructions.
	parameter logic [6:0] op_lui    = 7'b0110111;
	parameter logic [6:0] op_auipc  = 7'b0010111;
	parameter logic [6:0] op_jal    = 7'b1101111;
	parameter logic [6:0] op_jalr   = 7'b1100111;
	parameter logic [6:0] op_branch = 7'b1100011;
	parameter logic [6:0] op_load   = 7'b0000011;
	parameter logic [6:0] op_store  = 7'b0100011;
	parameter logic [6:0] op_imm    = 7'b0010011;
	parameter logic [6:0] op_reg    = 7'b0110011;

	// integer operations.
	parameter logic [2:0] f3_add_sub = 3'b000;
	parameter logic [2:0] f3_sll     = 3'b001;
	parameter logic [2:0] f3_slt     = 3'b010;
	parameter logic [2:0] f3_sltu    = 3'b011;
	parameter logic [2:0] f3_xor     = 3'b100;
	parameter logic [2:0] f3_srl_sra = 3'b101;
	parameter logic [2:0] f3_or      = 3'b110;
	parameter logic [2:0] f3_and     = 3'b111;

	// branches.
	parameter logic [2:0] f3_beq  = 3'b000;
	parameter logic [2:0] f3_bne  = 3'b001;
	parameter logic [2:0] f3_blt  = 3'b100;
	parameter logic [2:0] f3_bge  = 3'b101;
	parameter logic [2:0] f3_bltu = 3'b110;
	parameter logic [2:0] f3_bgeu = 3'b111;

	// bit 2 of the load codes marks a zero-extended load.
	parameter logic [2:0] f3_lb  = 3'b000;
	parameter logic [2:0] f3_lh  = 3'b001;
	parameter logic [2:0] f3_lw  = 3'b010;
	parameter logic [2:0] f3_ld  = 3'b011;
	parameter logic [2:0] f3_lbu = 3'b100;
	parameter logic [2:0] f3_lhu = 3'b101;
	parameter logic [2:0] f3_lwu = 3'b110;
	parameter logic [2:0] f3_sb  = 3'b000;
	parameter logic [2:0] f3_sh  = 3'b001;
	parameter logic [2:0] f3_sw  = 3'b010;
	parameter logic [2:0] f3_sd  = 3'b011;

	parameter logic [6:0] f7_alt = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_t;

endpackage

// ==== design/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_none,
		wb_pc4,
		wb_alu,
		wb_mem
	} wb_sel_e;

	// same codes as the branch funct3 field.
	typedef enum logic [2:0] {
		br_eq  = 3'b000,
		br_ne  = 3'b001,
		br_lt  = 3'b100,
		br_ge  = 3'b101,
		br_ltu = 3'b110,
		br_geu = 3'b111
	} br_cond_e;

	typedef enum logic [1:0] {
		mem_byte,
		mem_half,
		mem_word,
		mem_double
	} mem_size_e;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter logic [riscv_isa_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            redirect,
	input  logic [riscv_isa_pkg::xlen-1:0]  target,
	output logic [riscv_isa_pkg::xlen-1:0]  pc
);
	import riscv_isa_pkg::*;

	// one instruction retires per cycle, so the pc moves on every edge.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= reset_pc;
		end
		else if (redirect)
		begin
			pc <= target;
		end
		else
		begin
			pc <= pc + xlen'(4);
		end
	end

	// jump targets from execute must keep the fetch address word aligned.
	pc_align_a: assert property (@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00)
		else $error("pc not 4-byte aligned: %h", pc);

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [4:0]                      rs1,
	input  logic [4:0]                      rs2,
	input  logic [4:0]                      rd,
	input  logic                            rd_we,
	input  logic [riscv_isa_pkg::xlen-1:0]  rd_data,
	output logic [riscv_isa_pkg::xlen-1:0]  rs1_data,
	output logic [riscv_isa_pkg::xlen-1:0]  rs2_data
);
	import riscv_isa_pkg::*;

	// x0 has no storage.
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (rd_we && rd != 5'd0)
		begin
			regs[rd] <= rd_data;
		end
	end

	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  riscv_isa_pkg::inst_t            instr,
	output logic [4:0]                      rs1,
	output logic [4:0]                      rs2,
	output logic [4:0]                      rd,
	output logic [riscv_isa_pkg::xlen-1:0]  imm,
	output cpu_ctrl_pkg::alu_op_e           alu_op,
	output logic                            alu_a_pc,
	output logic                            alu_b_imm,
	output cpu_ctrl_pkg::br_cond_e          br_cond,
	output logic                            is_branch,
	output logic                            is_jal,
	output logic                            is_jalr,
	output logic                            mem_re,
	output logic                            mem_we,
	output cpu_ctrl_pkg::mem_size_e         mem_size,
	output logic                            mem_unsigned,
	output cpu_ctrl_pkg::wb_sel_e           wb_sel,
	output logic                            rd_we
);
	import riscv_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic [2:0]      f3;
	logic            shift_alt;
	logic            valid;

	function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
		alu_op_e op;
		case (funct3)
			f3_add_sub: op = alt ? alu_sub : alu_add;
			f3_sll:     op = alu_sll;
			f3_slt:     op = alu_slt;
			f3_sltu:    op = alu_sltu;
			f3_xor:     op = alu_xor;
			f3_srl_sra: op = alt ? alu_sra : alu_srl;
			f3_or:      op = alu_or;
			f3_and:     op = alu_and;
			default:    op = alu_add;
		endcase
		return op;
	endfunction

	assign f3 = instr.r_fmt.funct3;
	// rv64 immediate shifts use a 6-bit shamt, so funct7 bit 0 is shamt[5].
	assign shift_alt = (f3 == f3_srl_sra) && (instr.r_fmt.funct7[6:1] == f7_alt[6:1]);

	assign imm_i = {{(xlen-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
	assign imm_s = {{(xlen-12){instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
	assign imm_b = {{(xlen-13){instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
		instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {{(xlen-32){instr.u_fmt.imm[19]}}, instr.u_fmt.imm, 12'h000};
	assign imm_j = {{(xlen-21){instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
		instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

	assign rs2 = instr.r_fmt.rs2;
	assign rd  = instr.r_fmt.rd;
	// lui reads x0 so the alu passes the immediate straight through.
	assign rs1 = (instr.r_fmt.opcode == op_lui) ? 5'd0 : instr.r_fmt.rs1;

	always_comb
	begin
		imm          = '0;
		alu_op       = alu_add;
		alu_a_pc     = 1'b0;
		alu_b_imm    = 1'b0;
		br_cond      = br_eq;
		is_branch    = 1'b0;
		is_jal       = 1'b0;
		is_jalr      = 1'b0;
		mem_re       = 1'b0;
		mem_we       = 1'b0;
		mem_size     = mem_double;
		mem_unsigned = 1'b0;
		wb_sel       = wb_none;
		rd_we        = 1'b0;
		valid        = 1'b1;
		case (instr.r_fmt.opcode)
			op_lui, op_auipc:
			begin
				imm       = imm_u;
				alu_a_pc  = (instr.r_fmt.opcode == op_auipc);
				alu_b_imm = 1'b1;
				wb_sel    = wb_alu;
				rd_we     = 1'b1;
			end
			op_jal:
			begin
				imm    = imm_j;
				is_jal = 1'b1;
				wb_sel = wb_pc4;
				rd_we  = 1'b1;
			end
			op_jalr:
			begin
				imm     = imm_i;
				valid   = (f3 == 3'b000);
				is_jalr = valid;
				wb_sel  = wb_pc4;
				rd_we   = valid;
			end
			op_branch:
			begin
				imm = imm_b;
				case (f3)
					f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: br_cond = br_cond_e'(f3);
					default: valid = 1'b0;
				endcase
				is_branch = valid;
			end
			op_load:
			begin
				imm       = imm_i;
				alu_b_imm = 1'b1;
				case (f3)
					f3_lb, f3_lbu: mem_size = mem_byte;
					f3_lh, f3_lhu: mem_size = mem_half;
					f3_lw, f3_lwu: mem_size = mem_word;
					f3_ld:         mem_size = mem_double;
					default:       valid = 1'b0;
				endcase
				mem_unsigned = f3[2];
				mem_re       = valid;
				wb_sel       = wb_mem;
				rd_we        = valid;
			end
			op_store:
			begin
				imm       = imm_s;
				alu_b_imm = 1'b1;
				case (f3)
					f3_sb:   mem_size = mem_byte;
					f3_sh:   mem_size = mem_half;
					f3_sw:   mem_size = mem_word;
					f3_sd:   mem_size = mem_double;
					default: valid = 1'b0;
				endcase
				mem_we = valid;
			end
			op_imm:
			begin
				imm       = imm_i;
				alu_b_imm = 1'b1;
				alu_op    = alu_decode(f3, shift_alt);
				wb_sel    = wb_alu;
				rd_we     = 1'b1;
			end
			op_reg:
			begin
				alu_op = alu_decode(f3, instr.r_fmt.funct7 == f7_alt);
				wb_sel = wb_alu;
				rd_we  = 1'b1;
			end
			default: valid = 1'b0;
		endcase
	end

	unsupported_a: assert final ($isunknown(instr) || valid)
		else $error("unsupported instruction %h", instr);

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic [riscv_isa_pkg::xlen-1:0]  pc,
	input  logic [riscv_isa_pkg::xlen-1:0]  rs1_data,
	input  logic [riscv_isa_pkg::xlen-1:0]  rs2_data,
	input  logic [riscv_isa_pkg::xlen-1:0]  imm,
	input  cpu_ctrl_pkg::alu_op_e           alu_op,
	input  logic                            alu_a_pc,
	input  logic                            alu_b_imm,
	input  cpu_ctrl_pkg::br_cond_e          br_cond,
	input  logic                            is_branch,
	input  logic                            is_jal,
	input  logic                            is_jalr,
	output logic [riscv_isa_pkg::xlen-1:0]  alu_result,
	output logic                            redirect,
	output logic [riscv_isa_pkg::xlen-1:0]  target
);
	import riscv_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [5:0]      shamt;
	logic [xlen-1:0] jalr_sum;
	logic            taken;

	assign op_a  = alu_a_pc ? pc : rs1_data;
	assign op_b  = alu_b_imm ? imm : rs2_data;
	assign shamt = op_b[5:0];

	always_comb
	begin
		case (alu_op)
			alu_add:  alu_result = op_a + op_b;
			alu_sub:  alu_result = op_a - op_b;
			alu_sll:  alu_result = op_a << shamt;
			alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_xor:  alu_result = op_a ^ op_b;
			alu_srl:  alu_result = op_a >> shamt;
			alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
			alu_or:   alu_result = op_a | op_b;
			alu_and:  alu_result = op_a & op_b;
			default:  alu_result = '0;
		endcase
	end

	// the comparator always looks at the registers, never the immediate.
	always_comb
	begin
		case (br_cond)
			br_eq:   taken = (rs1_data == rs2_data);
			br_ne:   taken = (rs1_data != rs2_data);
			br_lt:   taken = ($signed(rs1_data) < $signed(rs2_data));
			br_ge:   taken = ($signed(rs1_data) >= $signed(rs2_data));
			br_ltu:  taken = (rs1_data < rs2_data);
			br_geu:  taken = (rs1_data >= rs2_data);
			default: taken = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_data + imm;
	assign target   = is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;
	assign redirect = (is_branch && taken) || is_jal || is_jalr;

endmodule

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic [riscv_isa_pkg::xlen-1:0]  pc,
	input  logic [riscv_isa_pkg::xlen-1:0]  alu_result,
	input  logic [riscv_isa_pkg::xlen-1:0]  rs2_data,
	input  logic                            mem_re,
	input  logic                            mem_we,
	input  cpu_ctrl_pkg::mem_size_e         mem_size,
	input  logic                            mem_unsigned,
	input  cpu_ctrl_pkg::wb_sel_e           wb_sel,
	input  logic [riscv_isa_pkg::xlen-1:0]  dmem_rdata,
	output logic [riscv_isa_pkg::xlen-1:0]  dmem_addr,
	output logic [riscv_isa_pkg::xlen-1:0]  dmem_wdata,
	output logic [7:0]                      dmem_wstrb,
	output logic                            dmem_re,
	output logic                            dmem_we,
	output logic [riscv_isa_pkg::xlen-1:0]  rd_data
);
	import riscv_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [2:0]      offset;
	logic [7:0]      size_mask;
	logic [2:0]      align_mask;
	logic            ext;
	logic [xlen-1:0] load_shifted;
	logic [xlen-1:0] load_data;

	assign offset    = alu_result[2:0];
	assign dmem_addr = {alu_result[xlen-1:3], 3'b000};
	assign dmem_re   = mem_re;
	assign dmem_we   = mem_we;

	// store data is copied to every lane and the strobes pick the right one.
	always_comb
	begin
		case (mem_size)
			mem_byte:
			begin
				dmem_wdata = {8{rs2_data[7:0]}};
				size_mask  = 8'h01;
				align_mask = 3'b000;
			end
			mem_half:
			begin
				dmem_wdata = {4{rs2_data[15:0]}};
				size_mask  = 8'h03;
				align_mask = 3'b001;
			end
			mem_word:
			begin
				dmem_wdata = {2{rs2_data[31:0]}};
				size_mask  = 8'h0f;
				align_mask = 3'b011;
			end
			default:
			begin
				dmem_wdata = rs2_data;
				size_mask  = 8'hff;
				align_mask = 3'b111;
			end
		endcase
	end

	assign dmem_wstrb = mem_we ? (size_mask << offset) : 8'h00;

	assign ext          = !mem_unsigned;
	assign load_shifted = dmem_rdata >> {offset, 3'b000};

	always_comb
	begin
		case (mem_size)
			mem_byte: load_data = {{(xlen-8){ext & load_shifted[7]}}, load_shifted[7:0]};
			mem_half: load_data = {{(xlen-16){ext & load_shifted[15]}}, load_shifted[15:0]};
			mem_word: load_data = {{(xlen-32){ext & load_shifted[31]}}, load_shifted[31:0]};
			default:  load_data = load_shifted;
		endcase
	end

	always_comb
	begin
		case (wb_sel)
			wb_pc4:  rd_data = pc + xlen'(4);
			wb_alu:  rd_data = alu_result;
			wb_mem:  rd_data = load_data;
			default: rd_data = '0;
		endcase
	end

	rw_excl_a: assert final (!(dmem_re && dmem_we))
		else $error("data read and write strobes both high");

	natural_align_a: assert final (!(mem_re || mem_we) || (offset & align_mask) == 3'b000)
		else $error("misaligned data access at %h", alu_result);

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
	parameter logic [riscv_isa_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                            clk,
	input  logic                            rst_n,
	output logic [riscv_isa_pkg::xlen-1:0]  imem_addr,
	input  logic [31:0]                     imem_rdata,
	output logic [riscv_isa_pkg::xlen-1:0]  dmem_addr,
	output logic [riscv_isa_pkg::xlen-1:0]  dmem_wdata,
	output logic [7:0]                      dmem_wstrb,
	output logic                            dmem_we,
	output logic                            dmem_re,
	input  logic [riscv_isa_pkg::xlen-1:0]  dmem_rdata
);
	import riscv_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [xlen-1:0] pc;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [xlen-1:0] imm;
	alu_op_e         alu_op;
	logic            alu_a_pc;
	logic            alu_b_imm;
	br_cond_e        br_cond;
	logic            is_branch;
	logic            is_jal;
	logic            is_jalr;
	logic            mem_re;
	logic            mem_we;
	mem_size_e       mem_size;
	logic            mem_unsigned;
	wb_sel_e         wb_sel;
	logic            rd_we;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] rd_data;
	logic [xlen-1:0] alu_result;
	logic            redirect;
	logic [xlen-1:0] target;

	assign imem_addr = pc;

	fetch_stage #(
		.reset_pc (reset_pc)
	) u_fetch (
		.clk      (clk),
		.rst_n    (rst_n),
		.redirect (redirect),
		.target   (target),
		.pc       (pc)
	);

	// the instruction word feeds decode in the same cycle it is fetched.
	decode_stage u_decode (
		.instr        (imem_rdata),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.imm          (imm),
		.alu_op       (alu_op),
		.alu_a_pc     (alu_a_pc),
		.alu_b_imm    (alu_b_imm),
		.br_cond      (br_cond),
		.is_branch    (is_branch),
		.is_jal       (is_jal),
		.is_jalr      (is_jalr),
		.mem_re       (mem_re),
		.mem_we       (mem_we),
		.mem_size     (mem_size),
		.mem_unsigned (mem_unsigned),
		.wb_sel       (wb_sel),
		.rd_we        (rd_we)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.rd_we    (rd_we),
		.rd_data  (rd_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	execute_stage u_execute (
		.pc         (pc),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.imm        (imm),
		.alu_op     (alu_op),
		.alu_a_pc   (alu_a_pc),
		.alu_b_imm  (alu_b_imm),
		.br_cond    (br_cond),
		.is_branch  (is_branch),
		.is_jal     (is_jal),
		.is_jalr    (is_jalr),
		.alu_result (alu_result),
		.redirect   (redirect),
		.target     (target)
	);

	mem_wb_stage u_mem_wb (
		.pc           (pc),
		.alu_result   (alu_result),
		.rs2_data     (rs2_data),
		.mem_re       (mem_re),
		.mem_we       (mem_we),
		.mem_size     (mem_size),
		.mem_unsigned (mem_unsigned),
		.wb_sel       (wb_sel),
		.dmem_rdata   (dmem_rdata),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_wstrb   (dmem_wstrb),
		.dmem_re      (dmem_re),
		.dmem_we      (dmem_we),
		.rd_data      (rd_data)
	);

endmodule

// ==== testbench/tb_program.svh ====
// each check result is written with sd x6 into the x2 area.
task automatic load_program();
	logic [2:0] conds [0:5];
	conds = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
	begin_test("reset_upper");
	put(enc_u(20'h00001, 5'd1, op_lui));
	put(enc_i(256, 5'd1, f3_add_sub, 5'd2, op_imm));
	put(enc_i(0, 5'd1, f3_ld, 5'd3, op_load));
	put(enc_i(8, 5'd1, f3_ld, 5'd4, op_load));
	put(enc_i(16, 5'd1, f3_ld, 5'd5, op_load));
	put_chk(enc_u(20'hfffff, 5'd6, op_lui));
	put_chk(enc_u(20'h12345, 5'd6, op_auipc));
	begin_test("alu_imm");
	put_chk(enc_i(-1234, 5'd3, f3_add_sub, 5'd6, op_imm));
	put_chk(enc_i(77, 5'd3, f3_slt, 5'd6, op_imm));
	put_chk(enc_i(-1, 5'd3, f3_sltu, 5'd6, op_imm));
	put_chk(enc_i(-1365, 5'd3, f3_xor, 5'd6, op_imm));
	put_chk(enc_i(12'h2f0, 5'd3, f3_or, 5'd6, op_imm));
	put_chk(enc_i(-256, 5'd3, f3_and, 5'd6, op_imm));
	put_chk(enc_i(37, 5'd3, f3_sll, 5'd6, op_imm));
	put_chk(enc_i(45, 5'd3, f3_srl_sra, 5'd6, op_imm));
	put_chk(enc_i(12'h40d, 5'd3, f3_srl_sra, 5'd6, op_imm));
	begin_test("alu_reg");
	for (int k = 0; k < 8; k++)
		put_chk(enc_r(7'h00, 5'd4, 5'd3, 3'(k), 5'd6));
	put_chk(enc_r(f7_alt, 5'd4, 5'd3, f3_add_sub, 5'd6));
	put_chk(enc_r(f7_alt, 5'd4, 5'd3, f3_srl_sra, 5'd6));
	put_chk(enc_r(7'h00, 5'd3, 5'd4, f3_slt, 5'd6));
	put_chk(enc_r(7'h00, 5'd3, 5'd4, f3_sltu, 5'd6));
	begin_test("stores");
	for (int k = 0; k < 8; k++)
		put(enc_s(768 + k, 5'd4, 5'd1, f3_sb));
	for (int k = 0; k < 4; k++)
		put(enc_s(776 + 2 * k, 5'd4, 5'd1, f3_sh));
	put(enc_s(784, 5'd4, 5'd1, f3_sw));
	put(enc_s(788, 5'd4, 5'd1, f3_sw));
	put(enc_s(792, 5'd4, 5'd1, f3_sd));
	begin_test("loads");
	for (int k = 0; k < 8; k++)
	begin
		put_chk(enc_i(k, 5'd1, f3_lb, 5'd6, op_load));
		put_chk(enc_i(k, 5'd1, f3_lbu, 5'd6, op_load));
	end
	for (int k = 0; k < 4; k++)
	begin
		put_chk(enc_i(8 + 2 * k, 5'd1, f3_lh, 5'd6, op_load));
		put_chk(enc_i(8 + 2 * k, 5'd1, f3_lhu, 5'd6, op_load));
	end
	for (int k = 0; k < 2; k++)
	begin
		put_chk(enc_i(16 + 4 * k, 5'd1, f3_lw, 5'd6, op_load));
		put_chk(enc_i(16 + 4 * k, 5'd1, f3_lwu, 5'd6, op_load));
	end
	put_chk(enc_i(24, 5'd1, f3_ld, 5'd6, op_load));
	begin_test("branches");
	put(enc_i(0, 5'd0, f3_add_sub, 5'd6, op_imm));
	// each condition sees a greater, a smaller and an equal pair.
	for (int k = 0; k < 6; k++)
	begin
		put(enc_b(8, 5'd4, 5'd3, conds[k]));
		put(enc_i(1, 5'd6, f3_add_sub, 5'd6, op_imm));
		put(enc_b(8, 5'd3, 5'd4, conds[k]));
		put(enc_i(1, 5'd6, f3_add_sub, 5'd6, op_imm));
		put(enc_b(8, 5'd3, 5'd3, conds[k]));
		put(enc_i(1, 5'd6, f3_add_sub, 5'd6, op_imm));
	end
	store_x6();
	begin_test("jumps");
	put(enc_j(8, 5'd6));
	put(enc_i(0, 5'd0, f3_add_sub, 5'd6, op_imm));
	store_x6();
	put(enc_u(20'h00000, 5'd7, op_auipc));
	put(enc_i(13, 5'd7, 3'b000, 5'd6, op_jalr));
	put(enc_i(0, 5'd0, f3_add_sub, 5'd6, op_imm));
	store_x6();
	begin_test("x0_discard");
	put(enc_i(5, 5'd3, f3_add_sub, 5'd0, op_imm));
	put(enc_r(7'h00, 5'd4, 5'd3, f3_add_sub, 5'd0));
	put(enc_i(0, 5'd1, f3_ld, 5'd0, op_load));
	put(enc_u(20'h00005, 5'd0, op_lui));
	put(enc_s(chk_off, 5'd0, 5'd2, f3_sd));
	put(enc_j(0, 5'd0));
endtask

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
	import riscv_isa_pkg::*;

	localparam logic [xlen-1:0] reset_pc = 64'h40;

	logic            clk;
	logic            rst_n;
	logic [xlen-1:0] imem_addr;
	logic [31:0]     imem_rdata;
	logic [xlen-1:0] dmem_addr;
	logic [xlen-1:0] dmem_wdata;
	logic [7:0]      dmem_wstrb;
	logic            dmem_we;
	logic            dmem_re;
	logic [xlen-1:0] dmem_rdata;

	logic [31:0] imem [0:255];
	logic [63:0] dmem [0:255];
	int          prog_test [0:255];
	string       names [0:15];
	int          test_err [0:15];
	int          ptr;
	int          cur;
	int          chk_off;
	logic [31:0] halt_word;

	// reference model state.
	logic [63:0] m_pc;
	logic [63:0] m_reg [0:31];
	logic [63:0] m_mem [0:255];
	logic [63:0] exp_pc;
	logic [63:0] nxt_pc;
	logic        exp_we;
	logic        exp_re;
	logic [7:0]  exp_strb;
	logic [63:0] exp_wdata;
	logic [63:0] exp_addr;
	int          exp_test;
	logic        wb_en;
	logic [4:0]  wb_rd;
	logic [63:0] wb_val;
	int          cycles;
	int          pending;
	int          last_test;
	bit          done;

	rv_core #(
		.reset_pc (reset_pc)
	) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wstrb (dmem_wstrb),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_rdata (dmem_rdata)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	assign imem_rdata = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[10:3]];

	always @(posedge clk)
	begin
		if (rst_n && dmem_we)
		begin
			for (int k = 0; k < 8; k++)
				if (dmem_wstrb[k])
					dmem[dmem_addr[10:3]][8*k +: 8] <= dmem_wdata[8*k +: 8];
		end
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic begin_test(input string n);
		cur++;
		names[cur] = n;
		test_err[cur] = 0;
	endtask

	task automatic put(input logic [31:0] w);
		imem[ptr] = w;
		prog_test[ptr] = cur;
		ptr++;
	endtask

	task automatic store_x6();
		put(enc_s(chk_off, 5'd6, 5'd2, f3_sd));
		chk_off += 8;
	endtask

	task automatic put_chk(input logic [31:0] w);
		put(w);
		store_x6();
	endtask

	`include "tb_program.svh"

	function automatic logic [63:0] alu(input logic [2:0] f3, input logic alt,
		input logic [63:0] x, input logic [63:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[5:0];
			3'd2: return {63'd0, $signed(x) < $signed(y)};
			3'd3: return {63'd0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[5:0]) : x >> y[5:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic [63:0] lane_mask(input logic [7:0] strb);
		logic [63:0] m;
		for (int k = 0; k < 8; k++)
			m[8*k +: 8] = {8{strb[k]}};
		return m;
	endfunction

	// works out what the instruction at m_pc should do, without committing it.
	task automatic evaluate();
		logic [31:0] w;
		logic [2:0]  f3;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] ii;
		logic [63:0] addr;
		logic [63:0] dw;
		logic        take;
		w  = imem[m_pc[9:2]];
		f3 = w[14:12];
		a  = m_reg[w[19:15]];
		b  = m_reg[w[24:20]];
		ii = {{52{w[31]}}, w[31:20]};
		exp_pc = m_pc;
		nxt_pc = m_pc + 64'd4;
		exp_we = 1'b0;
		exp_re = 1'b0;
		exp_strb = 8'h00;
		exp_wdata = '0;
		exp_addr = '0;
		exp_test = prog_test[m_pc[9:2]];
		wb_en = 1'b1;
		wb_rd = w[11:7];
		wb_val = '0;
		case (w[6:0])
			op_lui:   wb_val = {{32{w[31]}}, w[31:12], 12'h000};
			op_auipc: wb_val = m_pc + {{32{w[31]}}, w[31:12], 12'h000};
			op_jal:
			begin
				wb_val = m_pc + 64'd4;
				nxt_pc = m_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			op_jalr:
			begin
				wb_val = m_pc + 64'd4;
				nxt_pc = (a + ii) & ~64'd1;
			end
			op_branch:
			begin
				wb_en = 1'b0;
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take)
					nxt_pc = m_pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			op_load:
			begin
				addr = a + ii;
				exp_re = 1'b1;
				exp_addr = addr & ~64'd7;
				dw = m_mem[addr[10:3]] >> (addr[2:0] * 8);
				case (f3[1:0])
					2'd0: wb_val = f3[2] ? {56'd0, dw[7:0]} : {{56{dw[7]}}, dw[7:0]};
					2'd1: wb_val = f3[2] ? {48'd0, dw[15:0]} : {{48{dw[15]}}, dw[15:0]};
					2'd2: wb_val = f3[2] ? {32'd0, dw[31:0]} : {{32{dw[31]}}, dw[31:0]};
					default: wb_val = dw;
				endcase
			end
			op_store:
			begin
				wb_en = 1'b0;
				addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
				exp_we = 1'b1;
				exp_addr = addr & ~64'd7;
				exp_strb = 8'((16'd1 << (16'd1 << f3[1:0])) - 16'd1) << addr[2:0];
				exp_wdata = b << (addr[2:0] * 8);
			end
			op_imm:   wb_val = alu(f3, w[30] && f3 == 3'd5, a, ii);
			default:  wb_val = alu(f3, w[30], a, b);
		endcase
	endtask

	task automatic commit();
		if (wb_en && wb_rd != 5'd0)
			m_reg[wb_rd] = wb_val;
		for (int k = 0; k < 8; k++)
			if (exp_strb[k])
				m_mem[exp_addr[10:3]][8*k +: 8] = exp_wdata[8*k +: 8];
		m_pc = nxt_pc;
	endtask

	task automatic report_test(input int id);
		$display("%-12s %s, %0d errors", names[id], test_err[id] == 0 ? "ok" : "FAILED",
			test_err[id]);
	endtask

	task automatic note_error(input string what, input int id, input logic [63:0] e,
		input logic [63:0] a);
		$display("MISMATCH %s %s expected %h actual %h", names[id], what, e, a);
		test_err[id]++;
	endtask

	always @(posedge clk)
	begin
		if (pending >= 0)
		begin
			report_test(pending);
			pending = -1;
		end
		if (!rst_n)
		begin
			m_pc = reset_pc;
			for (int k = 0; k < 32; k++)
				m_reg[k] = '0;
			cycles = 0;
			evaluate();
			last_test = exp_test;
		end
		else if (!done)
		begin
			commit();
			cycles++;
			evaluate();
			if (exp_test != last_test)
			begin
				pending = last_test;
				last_test = exp_test;
			end
			if (imem[m_pc[9:2]] == halt_word)
				done = 1'b1;
		end
	end

	pc_a: assert property (@(posedge clk) disable iff (!rst_n) imem_addr == exp_pc)
		else note_error("imem_addr", $sampled(exp_test), $sampled(exp_pc), $sampled(imem_addr));

	we_a: assert property (@(posedge clk) disable iff (!rst_n) dmem_we == exp_we)
		else note_error("dmem_we", $sampled(exp_test), $sampled(exp_we), $sampled(dmem_we));

	re_a: assert property (@(posedge clk) disable iff (!rst_n) dmem_re == exp_re)
		else note_error("dmem_re", $sampled(exp_test), $sampled(exp_re), $sampled(dmem_re));

	addr_a: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_we || dmem_re) |-> dmem_addr == exp_addr)
		else note_error("dmem_addr", $sampled(exp_test), $sampled(exp_addr),
			$sampled(dmem_addr));

	strb_a: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_we |-> dmem_wstrb == exp_strb)
		else note_error("dmem_wstrb", $sampled(exp_test), $sampled(exp_strb),
			$sampled(dmem_wstrb));

	// only the lanes that are written carry meaning.
	wdata_a: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_we |-> (dmem_wdata & lane_mask(exp_strb)) == (exp_wdata & lane_mask(exp_strb)))
		else note_error("dmem_wdata", $sampled(exp_test),
			$sampled(exp_wdata & lane_mask(exp_strb)),
			$sampled(dmem_wdata & lane_mask(exp_strb)));

	initial
	begin
		logic [31:0] seed;
		logic [31:0] hi;
		int          limit;
		int          total;
		int          failed;
		bit          timed_out;
		rst_n = 1'b0;
		done = 1'b0;
		pending = -1;
		cur = -1;
		chk_off = 0;
		timed_out = 1'b0;
		halt_word = enc_j(0, 5'd0);
		seed = 32'h6955f533;
		for (int i = 0; i < 256; i++)
		begin
			seed = lcg(seed);
			hi = seed;
			seed = lcg(seed);
			dmem[i] = {hi, seed};
			m_mem[i] = {hi, seed};
			imem[i] = halt_word;
			prog_test[i] = 0;
		end
		ptr = reset_pc[9:2];
		load_program();
		limit = 2 * (ptr - reset_pc[9:2]) + 20;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		while (!done && cycles < limit)
			@(posedge clk);
		if (!done)
		begin
			$display("timeout: no halt loop reached after %0d cycles", limit);
			timed_out = 1'b1;
		end
		repeat (2) @(posedge clk);
		if (pending >= 0)
			report_test(pending);
		report_test(last_test);
		total = 0;
		failed = 0;
		for (int k = 0; k <= cur; k++)
		begin
			total += test_err[k];
			if (test_err[k] != 0)
				failed++;
		end
		$display("%0d tests, %0d failing, %0d errors", cur + 1, failed, total);
		if (total == 0 && !timed_out)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+testbench
design/riscv_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/riscv_isa_pkg.sv
  - design/cpu_ctrl_pkg.sv
  - design/fetch_stage.sv
  - design/reg_file.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/mem_wb_stage.sv
  - design/rv_core.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/core_tb.sv
